// File: Makefile
# Verilator build and run of the tone separator testbench

VERILATOR ?= verilator
TOP       ?= tb_tone_separator
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/ctrl_pkg.sv
/* control-side types for the frame sequencer */

`default_nettype none

package ctrl_pkg;

    // one full frame cycle runs through these in order
    typedef enum logic [2:0] {
        CAPTURE = 3'd0,  // fill the frame buffer
        SEND    = 3'd1,  // stream samples out under credit
        DRAIN   = 3'd2,  // last sample on the bus
        COLLECT = 3'd3,  // spectrum bins coming back
        REPORT  = 3'd4   // latch peaks, then tone_valid
    } seq_state_t;

endpackage : ctrl_pkg

`default_nettype wire

// File: hw/dsp_pkg.sv
/* data-side types: raw and signed samples, bin indices, magnitudes */

`default_nettype none

`include "tone_defines.svh"

package dsp_pkg;

    // offset binary, straight from the adc pins
    typedef logic [`SAMPLE_W-1:0] adc_sample_t;

    // two's complement, midpoint removed
    typedef logic signed [`SAMPLE_W-1:0] xf_sample_t;

    typedef logic [`ADDR_W-1:0] bin_idx_t;  // sample address or bin number

    // unsigned spectrum magnitude
    typedef logic [`MAG_W-1:0] bin_mag_t;

endpackage : dsp_pkg

`default_nettype wire

// File: hw/frame_buffer.sv
/* frame sample memory with registered read
   raw offset-binary samples leave as signed samples */

`timescale 1ns/1ps
`default_nettype none

`include "tone_defines.svh"

module frame_buffer import dsp_pkg::*; (
    input  wire         AD0_CLK,
    input  wire         buf_wr,
    input  wire         buf_rd,
    input  wire         bin_idx_t addr,
    input  wire         adc_sample_t ad0,
    output xf_sample_t  xf_data
);

    adc_sample_t mem [`FRAME_LEN];  // raw samples, one frame

    always_ff @(posedge AD0_CLK) begin
        if (buf_wr) begin
            mem[addr] <= ad0;
        end
    end

    // midpoint removed on the read side, wraps mod 2^SAMPLE_W
    always_ff @(posedge AD0_CLK) begin
        if (buf_rd) begin
            xf_data <= xf_sample_t'(mem[addr] - adc_sample_t'(`ADC_OFFSET));
        end
    end

endmodule : frame_buffer

`default_nettype wire

// File: hw/frame_counter.sv
/* index counter shared by capture, send and collect, with terminal flag */

`timescale 1ns/1ps
`default_nettype none

`include "tone_defines.svh"

module frame_counter import dsp_pkg::*; (
    input  wire      AD0_CLK,
    input  wire      rst,
    input  wire      cnt_clear,  // wins over cnt_step
    input  wire      cnt_step,
    output bin_idx_t cnt_value,
    output logic     cnt_last
);

    // phases never overlap, so one counter serves all of them
    always_ff @(posedge AD0_CLK) begin
        if (rst || cnt_clear) begin
            cnt_value <= '0;
        end else if (cnt_step) begin
            cnt_value <= cnt_value + 1'b1;  // wraps to 0 after the last index
        end
    end

    // terminal index, seen in the same cycle
    assign cnt_last = (cnt_value == bin_idx_t'(`FRAME_LEN - 1));

endmodule : frame_counter

`default_nettype wire

// File: hw/frame_sequencer.sv
/* frame state machine: capture, credit-limited send, spectrum collect, report
   keeps the credit count for the sample stream */

`timescale 1ns/1ps
`default_nettype none

`include "tone_defines.svh"

module frame_sequencer import ctrl_pkg::*; (
    input  wire  AD0_CLK,
    input  wire  rst,
    input  wire  xf_credit,   // one credit back per pulse
    input  wire  bin_valid,
    input  wire  bin_last,
    input  wire  cnt_last,
    output logic capturing,
    output logic buf_wr,
    output logic buf_rd,
    output logic cnt_clear,
    output logic cnt_step,
    output logic peak_clear,
    output logic peak_done,
    output logic xf_valid,
    output logic xf_last,
    output logic tone_valid
);

    seq_state_t           state;
    logic [`CREDIT_W-1:0] credits;

    assign buf_wr     = capturing;
    assign buf_rd     = (state == SEND) && (credits != '0);  // only with a credit in hand
    assign cnt_step   = capturing || buf_rd || ((state == COLLECT) && bin_valid);
    assign cnt_clear  = (state == DRAIN) || (state == REPORT);
    assign peak_clear = (state == DRAIN);
    assign peak_done  = (state == REPORT);

    always_ff @(posedge AD0_CLK) begin
        if (rst) begin
            state      <= CAPTURE;
            capturing  <= 1'b0;
            xf_valid   <= 1'b0;
            xf_last    <= 1'b0;
            tone_valid <= 1'b0;
        end else begin
            xf_valid   <= buf_rd;              // read data lands one cycle later
            xf_last    <= buf_rd && cnt_last;
            tone_valid <= (state == REPORT);
            case (state)
                CAPTURE: begin
                    if (!capturing) begin
                        capturing <= 1'b1;
                    end else if (cnt_last) begin
                        capturing <= 1'b0;     // frame full
                        state     <= SEND;
                    end
                end
                SEND: if (buf_rd && cnt_last) state <= DRAIN;
                DRAIN: state <= COLLECT;       // xf_last is on the bus here
                COLLECT: if (bin_valid && bin_last) state <= REPORT;
                REPORT: state <= CAPTURE;
                default: state <= CAPTURE;
            endcase
        end
    end

    // credit account, simultaneous issue and return cancel out
    always_ff @(posedge AD0_CLK) begin
        if (rst) begin
            credits <= `CREDIT_W'(`XF_CREDITS);
        end else if (buf_rd && !xf_credit) begin
            credits <= credits - 1'b1;
        end else if (xf_credit && !buf_rd && (credits < `CREDIT_W'(`XF_CREDITS))) begin
            credits <= credits + 1'b1;
        end
    end

endmodule : frame_sequencer

`default_nettype wire

// File: hw/peak_finder.sv
/* two-largest search over in-band spectrum bins
   result registered on peak_done, ordered by bin index */

`timescale 1ns/1ps
`default_nettype none

`include "tone_defines.svh"

module peak_finder import dsp_pkg::*; (
    input  wire      AD0_CLK,
    input  wire      rst,
    input  wire      peak_clear,
    input  wire      bin_valid,
    input  wire      peak_done,
    input  wire      bin_idx_t bin_idx,
    input  wire      bin_mag_t bin_mag,
    output bin_idx_t tone_lo_idx,
    output bin_idx_t tone_hi_idx,
    output bin_mag_t tone_lo_mag,
    output bin_mag_t tone_hi_mag
);

    bin_idx_t best_idx;
    bin_mag_t best_mag;
    bin_idx_t sec_idx;
    bin_mag_t sec_mag;
    logic     in_band;

    // skip dc and the upper mirror half
    assign in_band = bin_valid && (bin_idx != '0) && (bin_idx < (`FRAME_LEN / 2));

    // strictly greater displaces, so an equal later bin loses
    always_ff @(posedge AD0_CLK) begin
        if (rst || peak_clear) begin
            best_idx <= '0;
            best_mag <= '0;
            sec_idx  <= '0;
            sec_mag  <= '0;
        end else if (in_band) begin
            if (bin_mag > best_mag) begin
                sec_idx  <= best_idx;  // old best slides down
                sec_mag  <= best_mag;
                best_idx <= bin_idx;
                best_mag <= bin_mag;
            end else if (bin_mag > sec_mag) begin
                sec_idx <= bin_idx;
                sec_mag <= bin_mag;
            end
        end
    end

    // empty slots stay at index 0 and sort to lo
    always_ff @(posedge AD0_CLK) begin
        if (rst || peak_clear) begin
            tone_lo_idx <= '0;
            tone_lo_mag <= '0;
            tone_hi_idx <= '0;
            tone_hi_mag <= '0;
        end else if (peak_done) begin
            if (best_idx < sec_idx) begin
                tone_lo_idx <= best_idx;
                tone_lo_mag <= best_mag;
                tone_hi_idx <= sec_idx;
                tone_hi_mag <= sec_mag;
            end else begin
                tone_lo_idx <= sec_idx;
                tone_lo_mag <= sec_mag;
                tone_hi_idx <= best_idx;
                tone_hi_mag <= best_mag;
            end
        end
    end

endmodule : peak_finder

`default_nettype wire

// File: hw/tone_defines.svh
/* frame, sample, magnitude and credit sizes shared by the tone separator */

`ifndef TONE_DEFINES_SVH
`define TONE_DEFINES_SVH

// samples per frame, also the number of spectrum bins
`define FRAME_LEN 1024

// address and bin index width, log2 of FRAME_LEN
`define ADDR_W 10

`define SAMPLE_W 8   // raw adc sample
`define MAG_W 16     // magnitude word from the engine

// credits granted by the transform engine
`define XF_CREDITS 4

// holds 0..XF_CREDITS
`define CREDIT_W 3

// offset-binary midpoint of the adc
`define ADC_OFFSET 128

`endif

// File: hw/tone_separator_top.sv
/* tone separator top: sequencer, shared counter, frame buffer, peak finder */

`timescale 1ns/1ps
`default_nettype none

module tone_separator_top import dsp_pkg::*; (
    input  wire         AD0_CLK,
    input  wire         rst,
    input  wire         adc_sample_t ad0,
    output logic        capturing,
    output xf_sample_t  xf_data,      // to the transform engine
    output logic        xf_valid,
    output logic        xf_last,
    input  wire         xf_credit,
    input  wire         bin_mag_t bin_mag,  // spectrum back, no back-pressure
    input  wire         bin_valid,
    input  wire         bin_last,
    output logic        tone_valid,
    output bin_idx_t    tone_lo_idx,
    output bin_idx_t    tone_hi_idx,
    output bin_mag_t    tone_lo_mag,
    output bin_mag_t    tone_hi_mag
);

    logic     cnt_clear;
    logic     cnt_step;
    bin_idx_t cnt_value;  // buffer address and bin index
    logic     cnt_last;
    logic     buf_wr;
    logic     buf_rd;
    logic     peak_clear;
    logic     peak_done;

    frame_sequencer u_seq (
        .AD0_CLK    (AD0_CLK),
        .rst        (rst),
        .xf_credit  (xf_credit),
        .bin_valid  (bin_valid),
        .bin_last   (bin_last),
        .cnt_last   (cnt_last),
        .capturing  (capturing),
        .buf_wr     (buf_wr),
        .buf_rd     (buf_rd),
        .cnt_clear  (cnt_clear),
        .cnt_step   (cnt_step),
        .peak_clear (peak_clear),
        .peak_done  (peak_done),
        .xf_valid   (xf_valid),
        .xf_last    (xf_last),
        .tone_valid (tone_valid)
    );

    frame_counter u_cnt (
        .AD0_CLK   (AD0_CLK),
        .rst       (rst),
        .cnt_clear (cnt_clear),
        .cnt_step  (cnt_step),
        .cnt_value (cnt_value),
        .cnt_last  (cnt_last)
    );

    frame_buffer u_buf (
        .AD0_CLK (AD0_CLK),
        .buf_wr  (buf_wr),
        .buf_rd  (buf_rd),
        .addr    (cnt_value),
        .ad0     (ad0),
        .xf_data (xf_data)
    );

    peak_finder u_peak (
        .AD0_CLK     (AD0_CLK),
        .rst         (rst),
        .peak_clear  (peak_clear),
        .bin_valid   (bin_valid),
        .peak_done   (peak_done),
        .bin_idx     (cnt_value),
        .bin_mag     (bin_mag),
        .tone_lo_idx (tone_lo_idx),
        .tone_hi_idx (tone_hi_idx),
        .tone_lo_mag (tone_lo_mag),
        .tone_hi_mag (tone_hi_mag)
    );

endmodule : tone_separator_top

`default_nettype wire

// File: list.f
+incdir+hw
hw/ctrl_pkg.sv
hw/dsp_pkg.sv
hw/frame_sequencer.sv
hw/frame_counter.sv
hw/frame_buffer.sv
hw/peak_finder.sv
hw/tone_separator_top.sv
verification/tone_separator_asserts.sv
verification/tb_tone_separator.sv

// File: verification/tb_tone_separator.sv
/* testbench: clock, reset, random adc capture, transform engine model with credit returns,
   two-tone peak model and compare tasks */

`timescale 1ns/1ps
`default_nettype none

`include "tone_defines.svh"

module tb_tone_separator import dsp_pkg::*; ();

    logic        AD0_CLK;
    logic        rst;
    adc_sample_t ad0;
    logic        xf_credit;
    bin_mag_t    bin_mag;
    logic        bin_valid;
    logic        bin_last;
    logic        capturing;
    xf_sample_t  xf_data;
    logic        xf_valid;
    logic        xf_last;
    logic        tone_valid;
    bin_idx_t    tone_lo_idx;
    bin_idx_t    tone_hi_idx;
    bin_mag_t    tone_lo_mag;
    bin_mag_t    tone_hi_mag;

    int          seed = 28;
    int          cyc;
    int          frame;
    int          wr_n;          // samples captured this frame
    int          rd_n;          // samples received this frame
    int          in_flight;     // received but not yet credited
    int          hold_until;    // no credit returns before this cycle
    int          last_due;
    logic        got_last;
    logic        tone_expect;
    int          due_q[$];      // cycles at which credits go back
    adc_sample_t rec[`FRAME_LEN];
    bin_mag_t    spec[`FRAME_LEN];

    tone_separator_top dut0 (
        .AD0_CLK     (AD0_CLK),
        .rst         (rst),
        .ad0         (ad0),
        .capturing   (capturing),
        .xf_data     (xf_data),
        .xf_valid    (xf_valid),
        .xf_last     (xf_last),
        .xf_credit   (xf_credit),
        .bin_mag     (bin_mag),
        .bin_valid   (bin_valid),
        .bin_last    (bin_last),
        .tone_valid  (tone_valid),
        .tone_lo_idx (tone_lo_idx),
        .tone_hi_idx (tone_hi_idx),
        .tone_lo_mag (tone_lo_mag),
        .tone_hi_mag (tone_hi_mag)
    );

    initial begin
        AD0_CLK = 1'b0;
        forever #20 AD0_CLK = ~AD0_CLK;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_sample(input string name, input xf_sample_t got, input xf_sample_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_idx(input string name, input bin_idx_t got, input bin_idx_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_mag(input string name, input bin_mag_t got, input bin_mag_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // engine side of one received sample
    task automatic receive_sample();
        int due;
        if (rd_n >= `FRAME_LEN) begin
            stop_on_error("a sample arrived after the end of the frame");
        end
        check_sample("xf_data", xf_data, xf_sample_t'(int'(rec[rd_n]) - `ADC_OFFSET));
        check_flag("xf_last", xf_last, rd_n == `FRAME_LEN - 1);
        got_last = xf_last;
        rd_n++;
        in_flight++;
        if (in_flight > `XF_CREDITS) begin
            stop_on_error("more samples in flight than credits granted");
        end
        if (frame[0] && rd_n == 300) begin
            hold_until = cyc + 60;  // odd frames, stall the stream
        end
        due = cyc + rand_below(7);
        if (due <= last_due) begin
            due = last_due + 1;  // one credit pulse per cycle
        end
        due_q.push_back(due);
        last_due = due;
    endtask

    // next cycle, 2 ns after the edge: outputs settled, inputs driven
    task automatic tick();
        @(posedge AD0_CLK);
        #2;
        cyc++;
        xf_credit = 1'b0;
        if (due_q.size() > 0 && cyc >= hold_until && due_q[0] <= cyc) begin
            void'(due_q.pop_front());
            xf_credit = 1'b1;
            in_flight--;
        end
        ad0 = adc_sample_t'($random(seed));  // ignored outside capture
        if (capturing) begin
            if (wr_n == `FRAME_LEN) begin
                stop_on_error("capturing stayed high past one frame");
            end
            rec[wr_n] = ad0;
            wr_n++;
        end
        check_flag("tone_valid", tone_valid, tone_expect);
        if (xf_valid) begin
            receive_sample();
        end else begin
            check_flag("xf_last", xf_last, 1'b0);
        end
    endtask

    task automatic make_spectrum();
        int a;
        for (int i = 0; i < `FRAME_LEN; i++) begin
            spec[i] = bin_mag_t'($random(seed));
        end
        spec[0]   = '1;  // dc and mirror half, out of band
        spec[700] = '1;
        if (frame >= 2) begin
            a = 1 + rand_below(400);
            spec[a]      = '1;  // planted tie
            spec[a + 50] = '1;
            if (frame == 3) begin
                spec[a + 100] = '1;
            end
        end
    endtask

    task automatic send_spectrum();
        int gap;
        for (int i = 0; i < `FRAME_LEN; i++) begin
            gap = (rand_below(4) == 0) ? rand_below(5) : 0;
            repeat (gap) tick();
            bin_valid = 1'b1;
            bin_mag   = spec[i];
            bin_last  = (i == `FRAME_LEN - 1);
            tick();
            bin_valid = 1'b0;
            bin_last  = 1'b0;
        end
    endtask

    // largest in band first, then the largest of the rest, earliest bin on ties
    task automatic expect_peaks(output bin_idx_t lo_idx, output bin_mag_t lo_mag,
                                output bin_idx_t hi_idx, output bin_mag_t hi_mag);
        bin_mag_t m1;
        bin_mag_t m2;
        int       i1;
        int       i2;
        m1 = '0;
        i1 = 0;
        for (int i = 1; i < `FRAME_LEN / 2; i++) begin
            if (spec[i] > m1) begin
                m1 = spec[i];
                i1 = i;
            end
        end
        m2 = '0;
        i2 = 0;
        for (int i = 1; i < `FRAME_LEN / 2; i++) begin
            if (i != i1 && spec[i] > m2) begin
                m2 = spec[i];
                i2 = i;
            end
        end
        lo_idx = bin_idx_t'((i1 < i2) ? i1 : i2);
        lo_mag = (i1 < i2) ? m1 : m2;
        hi_idx = bin_idx_t'((i1 < i2) ? i2 : i1);
        hi_mag = (i1 < i2) ? m2 : m1;
    endtask

    initial begin
        bin_idx_t lo_idx;
        bin_idx_t hi_idx;
        bin_mag_t lo_mag;
        bin_mag_t hi_mag;
        int       waited;
        rst         = 1'b1;
        ad0         = '0;
        xf_credit   = 1'b0;
        bin_mag     = '0;
        bin_valid   = 1'b0;
        bin_last    = 1'b0;
        cyc         = 0;
        in_flight   = 0;
        hold_until  = 0;
        last_due    = 0;
        tone_expect = 1'b0;
        repeat (5) @(posedge AD0_CLK);
        #2;
        check_flag("capturing", capturing, 1'b0);
        check_flag("xf_valid", xf_valid, 1'b0);
        check_flag("tone_valid", tone_valid, 1'b0);
        rst = 1'b0;
        for (frame = 0; frame < 4; frame++) begin
            wr_n     = 0;
            rd_n     = 0;
            got_last = 1'b0;
            make_spectrum();
            tick();
            check_flag("capturing", capturing, 1'b1);  // capture starts right away
            waited = 0;
            while (capturing) begin
                tick();
                waited++;
                if (waited > `FRAME_LEN + 4) begin
                    stop_on_error("capture window never closed");
                end
            end
            if (wr_n != `FRAME_LEN) begin
                stop_on_error($sformatf("Error: capture length got 0x%h expected 0x%h",
                                        wr_n, `FRAME_LEN));
            end
            waited = 0;
            while (!got_last) begin
                tick();
                waited++;
                if (waited > 20000) begin
                    stop_on_error("timed out waiting for the last sample of the frame");
                end
            end
            tick();  // sequencer enters collect
            send_spectrum();
            tone_expect = 1'b1;
            tick();
            expect_peaks(lo_idx, lo_mag, hi_idx, hi_mag);
            check_idx("tone_lo_idx", tone_lo_idx, lo_idx);
            check_mag("tone_lo_mag", tone_lo_mag, lo_mag);
            check_idx("tone_hi_idx", tone_hi_idx, hi_idx);
            check_mag("tone_hi_mag", tone_hi_mag, hi_mag);
            tone_expect = 1'b0;
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule : tb_tone_separator

`default_nettype wire

// File: verification/tone_separator_asserts.sv
/* concurrent checks on the sample stream flags, the tone pulse and credit use */

`timescale 1ns/1ps
`default_nettype none

`include "tone_defines.svh"

module tone_separator_asserts (
    input wire AD0_CLK,
    input wire rst,
    input wire xf_valid,
    input wire xf_last,
    input wire xf_credit,
    input wire tone_valid
);

    int in_flight;  // sent and not yet credited

    always_ff @(posedge AD0_CLK) begin
        if (rst) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(xf_valid) - int'(xf_credit);
        end
    end

    last_with_valid: assert property (@(posedge AD0_CLK) disable iff (rst) xf_last |-> xf_valid)
        else $error("xf_last seen without xf_valid");

    tone_one_cycle: assert property (@(posedge AD0_CLK) disable iff (rst) tone_valid |=> !tone_valid)
        else $error("tone_valid held longer than one cycle");

    credit_bound: assert property (@(posedge AD0_CLK) disable iff (rst) in_flight <= `XF_CREDITS)
        else $error("samples in flight exceed the granted credits");

endmodule : tone_separator_asserts

bind tone_separator_top tone_separator_asserts u_asserts (
    .AD0_CLK    (AD0_CLK),
    .rst        (rst),
    .xf_valid   (xf_valid),
    .xf_last    (xf_last),
    .xf_credit  (xf_credit),
    .tone_valid (tone_valid)
);

`default_nettype wire
